// File: tb.f
mem_pkg.sv
ahb_pkg.sv
dmem_if.sv
dmem_router.sv
dmem_tcm.sv
dmem_timer.sv
dmem_ahb.sv
dmem_subsys_top.sv
tb_ahb_slave.sv
tb_dmem_subsys.sv

// File: Makefile
# Verilator build and run of the data-memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_dmem_subsys
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST OK
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_dmem_subsys.sv
// Testbench for the data-memory subsystem
// Stimulus table applied in a loop, shadow memory model, timer checks and timeout
`timescale 1ns/1ns

module tb_dmem_subsys import mem_pkg::*; ();

localparam int OP_FIX     = 0;   // Compare rdata under mask
localparam int OP_MEM     = 1;   // Shadow merged memory access
localparam int OP_MT1     = 2;   // Record mtime
localparam int OP_MT2     = 3;   // mtime must have advanced
localparam int OP_CMPSET  = 4;   // Compare low set above mtime
localparam int OP_IRQWAIT = 5;   // timer_irq must rise
localparam int OP_IRQLOW  = 6;   // timer_irq must drop

localparam logic [31:0] TCM_BASE = 32'h0048_0000;
localparam logic [31:0] TMR_BASE = 32'h0049_0000;
localparam logic [31:0] EXT_BASE = 32'h2000_0000;

typedef struct {
    mem_cmd_e   cmd;
    mem_width_e width;
    logic [31:0] addr;
    logic [31:0] wdata;
    mem_resp_e  resp;
    logic [31:0] rdata;
    logic [31:0] mask;
    int         op;
    bit         sync;      // Wait for all responses before issue
} row_t;

logic               clk;
logic               rst_n;
logic               dmem_req;
mem_cmd_e           dmem_cmd;
mem_width_e         dmem_width;
logic [31:0]        dmem_addr;
logic [31:0]        dmem_wdata;
logic               dmem_req_ack;
logic [31:0]        dmem_rdata;
mem_resp_e          dmem_resp;
logic               timer_irq;
logic [3:0]         hprot;
logic [2:0]         hburst;
logic [2:0]         hsize;
logic [1:0]         htrans;
logic               hmastlock;
logic [31:0]        haddr;
logic               hwrite;
logic [31:0]        hwdata;
logic               hready;
logic [31:0]        hrdata;
logic               hresp;

row_t        rows[$];
int          pend[$];
logic [31:0] shadow [logic [31:0]];
logic [31:0] last_mtime;
int          errs;
int          attr_errs;
int          rows_ok;
int          rows_bad;
int          done;
int          cycles;
int          limit;

dmem_subsys_top DUT (
    .clk(clk), .rst_n(rst_n),
    .dmem_req(dmem_req), .dmem_cmd(dmem_cmd), .dmem_width(dmem_width),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_req_ack(dmem_req_ack),
    .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp), .timer_irq(timer_irq),
    .hprot(hprot), .hburst(hburst), .hsize(hsize), .htrans(htrans),
    .hmastlock(hmastlock), .haddr(haddr), .hwrite(hwrite), .hwdata(hwdata),
    .hready(hready), .hrdata(hrdata), .hresp(hresp)
);

tb_ahb_slave i_slave (
    .clk(clk), .rst_n(rst_n), .htrans(htrans), .haddr(haddr), .hwrite(hwrite),
    .hsize(hsize), .hwdata(hwdata), .hready(hready), .hrdata(hrdata), .hresp(hresp)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// Run limit
always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
        $display("Timeout after %0d cycles with %0d of %0d rows done", cycles, done,
                 rows.size());
        $display("TEST FAILED");
        $finish;
    end
end

// AHB attributes on every address phase
always @(negedge clk) begin
    if (rst_n && htrans == 2'b10) begin
        if (hprot !== 4'b0001) begin   // Data access, user, no buffer or cache
            $display("FAIL hprot got %h exp %h", hprot, 4'b0001);
            attr_errs++;
        end
        if (hburst !== 3'b000) begin   // Single transfer
            $display("FAIL hburst got %h exp %h", hburst, 3'b000);
            attr_errs++;
        end
        if (hmastlock !== 1'b0) begin
            $display("FAIL hmastlock got %h exp %h", hmastlock, 1'b0);
            attr_errs++;
        end
    end
end

task automatic add_row(input mem_cmd_e cmd, input mem_width_e width, input logic [31:0] addr,
                       input logic [31:0] wdata, input mem_resp_e resp,
                       input logic [31:0] rdata, input logic [31:0] mask, input int op,
                       input bit sync);
    row_t r;
    r.cmd   = cmd;
    r.width = width;
    r.addr  = addr;
    r.wdata = wdata;
    r.resp  = resp;
    r.rdata = rdata;
    r.mask  = mask;
    r.op    = op;
    r.sync  = sync;
    rows.push_back(r);
endtask

// Lane merge of a write into an old word
function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wd,
                                            input mem_width_e width, input logic [1:0] bsel);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
        if ((width == MEM_WIDTH_WORD)
            || (width == MEM_WIDTH_HALF && bsel[1] == i[1])
            || (width == MEM_WIDTH_BYTE && bsel == i[1:0]))
            res[8*i +: 8] = wd[8*i +: 8];
    end
    return res;
endfunction

task automatic check_row(input int r, input mem_resp_e got_resp, input logic [31:0] got_rd);
    row_t        w;
    int          bad;
    int          n;
    logic [31:0] key;
    logic [31:0] exp;
    w   = rows[r];
    bad = 0;
    key = {w.addr[31:2], 2'b00};
    if (got_resp != w.resp) begin
        $display("FAIL row %0d dmem_resp got %h exp %h", r, got_resp, w.resp);
        bad++;
    end
    case (w.op)
        OP_MEM: begin
            if (w.cmd == MEM_CMD_WR) begin
                exp = shadow.exists(key) ? shadow[key] : 32'h0;
                shadow[key] = merge_lanes(exp, w.wdata, w.width, w.addr[1:0]);
            end else if (!shadow.exists(key)) begin
                $display("Row %0d reads a word that was never written", r);
                bad++;
            end else if (got_rd !== shadow[key]) begin
                $display("FAIL row %0d dmem_rdata got %h exp %h", r, got_rd, shadow[key]);
                bad++;
            end
        end
        OP_MT1: last_mtime = got_rd;
        OP_MT2: begin
            if (got_rd <= last_mtime) begin
                $display("Row %0d mtime did not advance past %h", r, last_mtime);
                bad++;
            end
            last_mtime = got_rd;
        end
        OP_IRQWAIT: begin
            n = 0;
            while (!timer_irq && n < 200) begin
                @(negedge clk);
                n++;
            end
            if (!timer_irq) begin
                $display("Row %0d timer_irq did not rise within 200 cycles", r);
                bad++;
            end
        end
        OP_IRQLOW: begin
            repeat (3) @(negedge clk);
            if (timer_irq !== 1'b0) begin
                $display("FAIL row %0d timer_irq got %h exp %h", r, timer_irq, 1'b0);
                bad++;
            end
        end
        OP_CMPSET: ;
        default: begin
            if (((got_rd ^ w.rdata) & w.mask) != 32'h0) begin
                $display("FAIL row %0d dmem_rdata got %h exp %h", r, got_rd & w.mask,
                         w.rdata & w.mask);
                bad++;
            end
        end
    endcase
    if (bad == 0) begin
        $display("Row %0d addr %h ok", r, w.addr);
        rows_ok++;
    end else begin
        rows_bad++;
    end
    errs += bad;
    done++;
endtask

// ------------------------------------------------------------------
// Stimulus table
// ------------------------------------------------------------------
task automatic build_table();
    // TCM word, byte and half writes, then reads
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TCM_BASE, 32'hdead_beef, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_BYTE, TCM_BASE + 2, 32'h00a5_0000, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_HALF, TCM_BASE, 32'h0000_1234, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TCM_BASE, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TCM_BASE + 32'h3fc, 32'hcafe_f00d, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TCM_BASE + 32'h3fc, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    // External bus under random wait states
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, EXT_BASE + 32'h10, 32'h1122_3344, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, EXT_BASE + 32'h24, 32'haabb_ccdd, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_BYTE, EXT_BASE + 32'h11, 32'h0000_5500, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_HALF, EXT_BASE + 32'h26, 32'h6677_0000, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, EXT_BASE + 32'h10, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, EXT_BASE + 32'h24, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    // Error window, then a normal access
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, 32'hffff_ff00, 0, MEM_RESP_RDY_ER, 0, 0, OP_FIX, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, EXT_BASE + 32'h30, 32'h5a5a_0f0f, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, EXT_BASE + 32'h30, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    // Timer, one access at a time
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TMR_BASE + 32'h14, 32'hffff_ffff, MEM_RESP_RDY_OK, 0, 0,
            OP_FIX, 1);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TMR_BASE + 32'h04, 0, MEM_RESP_RDY_OK, 0, 0, OP_FIX, 1);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TMR_BASE, 1, MEM_RESP_RDY_OK, 0, 0, OP_FIX, 1);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TMR_BASE, 0, MEM_RESP_RDY_OK, 1, 32'hffff_ffff, OP_FIX, 1);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TMR_BASE + 32'h08, 0, MEM_RESP_RDY_OK, 0, 0, OP_MT1, 1);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TMR_BASE + 32'h08, 0, MEM_RESP_RDY_OK, 0, 0, OP_MT2, 1);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TMR_BASE + 32'h10, 0, MEM_RESP_RDY_OK, 0, 0, OP_CMPSET, 1);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TMR_BASE + 32'h14, 0, MEM_RESP_RDY_OK, 0, 0, OP_IRQWAIT, 1);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TMR_BASE + 32'h14, 32'hffff_ffff, MEM_RESP_RDY_OK, 0, 0,
            OP_IRQLOW, 1);
    add_row(MEM_CMD_WR, MEM_WIDTH_BYTE, TMR_BASE, 1, MEM_RESP_RDY_ER, 0, 0, OP_FIX, 1);
    // Back to back across all three targets
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, TCM_BASE + 32'h10, 32'h0102_0304, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_WR, MEM_WIDTH_WORD, EXT_BASE + 32'h40, 32'h0a0b_0c0d, MEM_RESP_RDY_OK, 0, 0,
            OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TMR_BASE, 0, MEM_RESP_RDY_OK, 1, 32'hffff_ffff, OP_FIX, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TCM_BASE + 32'h10, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, EXT_BASE + 32'h40, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, TCM_BASE, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
    add_row(MEM_CMD_RD, MEM_WIDTH_WORD, EXT_BASE + 32'h10, 0, MEM_RESP_RDY_OK, 0, 0, OP_MEM, 0);
endtask

// ------------------------------------------------------------------
// Main sequence
// ------------------------------------------------------------------
initial begin
    int  idx;
    int  n;
    int  head;
    bit  presenting;
    rst_n      = 1'b0;
    dmem_req   = 1'b0;
    dmem_cmd   = MEM_CMD_RD;
    dmem_width = MEM_WIDTH_WORD;
    dmem_addr  = 32'h0;
    dmem_wdata = 32'h0;
    errs       = 0;
    attr_errs  = 0;
    rows_ok    = 0;
    rows_bad   = 0;
    done       = 0;
    cycles     = 0;
    last_mtime = 32'h0;
    build_table();
    n     = rows.size();
    limit = 40 * n + 2000;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (dmem_req_ack !== 1'b1 || dmem_resp !== MEM_RESP_NOTRDY || htrans !== 2'b00
        || timer_irq !== 1'b0) begin
        $display("State after reset is wrong");
        errs++;
    end

    idx        = 0;
    presenting = 0;
    while (done < n) begin
        @(posedge clk);
        if (!presenting) begin
            if (idx < n && (!rows[idx].sync || pend.size() == 0)) begin
                dmem_req   <= 1'b1;
                dmem_cmd   <= rows[idx].cmd;
                dmem_width <= rows[idx].width;
                dmem_addr  <= rows[idx].addr;
                dmem_wdata <= (rows[idx].op == OP_CMPSET) ? last_mtime + 32'd40
                                                          : rows[idx].wdata;
                presenting = 1;
            end else begin
                dmem_req <= 1'b0;
            end
        end
        @(negedge clk);
        // Acceptance at the coming edge, decided before any check waits
        if (presenting && dmem_req && dmem_req_ack) begin
            pend.push_back(idx);
            idx++;
            presenting = 0;
        end
        if (dmem_resp != MEM_RESP_NOTRDY) begin
            if (pend.size() == 0) begin
                $display("Response seen with no request outstanding");
                errs++;
            end else begin
                head = pend.pop_front();
                check_row(head, dmem_resp, dmem_rdata);
            end
        end
    end
    @(posedge clk);
    dmem_req <= 1'b0;

    // No stray responses afterwards
    repeat (10) begin
        @(negedge clk);
        if (dmem_resp != MEM_RESP_NOTRDY) begin
            $display("Extra response after the last row");
            errs++;
        end
    end

    errs += attr_errs;
    $display("Rows %0d, passed %0d, failed %0d, errors %0d", n, rows_ok, rows_bad, errs);
    if (errs == 0) begin
        $display("TEST OK");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule : tb_dmem_subsys

// File: tb_ahb_slave.sv
// AHB-Lite slave model for the data-memory testbench
// LFSR driven wait states, 64-word memory and an error window at the top pages
`timescale 1ns/1ns

module tb_ahb_slave
    import mem_pkg::*;
    import ahb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [1:0]         htrans,
    input  logic [DMEM_AW-1:0] haddr,
    input  logic               hwrite,
    input  logic [2:0]         hsize,
    input  logic [DMEM_DW-1:0] hwdata,
    output logic               hready,
    output logic [DMEM_DW-1:0] hrdata,
    output logic               hresp
);

logic [DMEM_DW-1:0] mem [64];
logic [31:0]        lfsr;
logic               dp_active;    // Data phase in progress
logic [DMEM_AW-1:0] dp_addr;
logic               dp_write;
logic [2:0]         dp_size;
logic               dp_err;
logic [1:0]         wait_cnt;
logic [1:0]         wait_new;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

assign hready = !dp_active || (wait_cnt == 2'd0);
assign hresp  = (dp_active && dp_err) ? HRESP_ERROR : HRESP_OKAY;
assign hrdata = dp_active ? mem[dp_addr[7:2]] : '0;

always @(posedge clk) begin
    if (!rst_n) begin
        dp_active <= 1'b0;
        wait_cnt  <= 2'd0;
        lfsr      = 32'ha81e_04c8;
    end else if (hready) begin
        // Finish the current data phase
        if (dp_active && dp_write && !dp_err) begin
            for (int i = 0; i < 4; i++) begin
                if ((dp_size == HSIZE_WORD)
                    || (dp_size == HSIZE_HALF && dp_addr[1] == i[1])
                    || (dp_size == HSIZE_BYTE && dp_addr[1:0] == i[1:0]))
                    mem[dp_addr[7:2]][8*i +: 8] <= hwdata[8*i +: 8];
            end
        end
        if (htrans == HTRANS_NONSEQ) begin
            lfsr        = lfsr_next(lfsr);
            wait_new[0] = lfsr[0];
            lfsr        = lfsr_next(lfsr);
            wait_new[1] = lfsr[0];
            dp_active <= 1'b1;
            dp_addr   <= haddr;
            dp_write  <= hwrite;
            dp_size   <= hsize;
            dp_err    <= (haddr[31:10] >= 22'hFFFFF);  // Error window
            wait_cnt  <= wait_new;
        end else begin
            dp_active <= 1'b0;
        end
    end else begin
        wait_cnt <= wait_cnt - 2'd1;
    end
end

endmodule : tb_ahb_slave

// File: dmem_subsys_top.sv
// Data-memory subsystem top level
// Router, TCM, machine timer and AHB-Lite bridge
`timescale 1ns/1ns

module dmem_subsys_top import mem_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    // Core data port
    input  logic               dmem_req,
    input  mem_cmd_e           dmem_cmd,
    input  mem_width_e         dmem_width,
    input  logic [DMEM_AW-1:0] dmem_addr,
    input  logic [DMEM_DW-1:0] dmem_wdata,
    output logic               dmem_req_ack,
    output logic [DMEM_DW-1:0] dmem_rdata,
    output mem_resp_e          dmem_resp,
    output logic               timer_irq,
    // External AHB-Lite bus
    output logic [3:0]         hprot,
    output logic [2:0]         hburst,
    output logic [2:0]         hsize,
    output logic [1:0]         htrans,
    output logic               hmastlock,
    output logic [DMEM_AW-1:0] haddr,
    output logic               hwrite,
    output logic [DMEM_DW-1:0] hwdata,
    input  logic               hready,
    input  logic [DMEM_DW-1:0] hrdata,
    input  logic               hresp
);

dmem_if tcm_if ();
dmem_if timer_if ();
dmem_if ahb_if ();

// ------------------------------------------------------------------
// Router and targets
// ------------------------------------------------------------------
dmem_router i_router (
    .clk          (clk          ),
    .rst_n        (rst_n        ),
    .dmem_req     (dmem_req     ),
    .dmem_cmd     (dmem_cmd     ),
    .dmem_width   (dmem_width   ),
    .dmem_addr    (dmem_addr    ),
    .dmem_wdata   (dmem_wdata   ),
    .dmem_req_ack (dmem_req_ack ),
    .dmem_rdata   (dmem_rdata   ),
    .dmem_resp    (dmem_resp    ),
    .tcm_port     (tcm_if       ),
    .timer_port   (timer_if     ),
    .ahb_port     (ahb_if       )
);

dmem_tcm i_tcm (
    .clk   (clk    ),
    .rst_n (rst_n  ),
    .bus   (tcm_if )
);

dmem_timer i_timer (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .bus       (timer_if  ),
    .timer_irq (timer_irq )
);

dmem_ahb i_ahb (
    .clk       (clk       ),
    .rst_n     (rst_n     ),
    .bus       (ahb_if    ),
    .hprot     (hprot     ),
    .hburst    (hburst    ),
    .hsize     (hsize     ),
    .htrans    (htrans    ),
    .hmastlock (hmastlock ),
    .haddr     (haddr     ),
    .hwrite    (hwrite    ),
    .hwdata    (hwdata    ),
    .hready    (hready    ),
    .hrdata    (hrdata    ),
    .hresp     (hresp     )
);

endmodule : dmem_subsys_top

// File: dmem_ahb.sv
// Data-memory to AHB-Lite bridge
// Three-phase FSM, one single transfer at a time
`timescale 1ns/1ns

module dmem_ahb
    import mem_pkg::*;
    import ahb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    dmem_if.target             bus,
    // AHB-Lite master
    output logic [3:0]         hprot,
    output logic [2:0]         hburst,
    output logic [2:0]         hsize,
    output logic [1:0]         htrans,
    output logic               hmastlock,
    output logic [DMEM_AW-1:0] haddr,
    output logic               hwrite,
    output logic [DMEM_DW-1:0] hwdata,
    input  logic               hready,
    input  logic [DMEM_DW-1:0] hrdata,
    input  logic               hresp
);

logic [1:0]         state;
logic [1:0]         state_next;
mem_cmd_e           cmd_q;
mem_width_e         width_q;
dmem_addr_u         addr_q;
logic [DMEM_DW-1:0] wdata_q;

// ------------------------------------------------------------------
// FSM
// ------------------------------------------------------------------
always_comb begin
    state_next = state;
    case (state)
        BR_IDLE: if (bus.req) state_next = BR_ADDR;
        BR_ADDR: if (hready) state_next = BR_DATA;
        BR_DATA: if (hready) state_next = BR_IDLE;
        default: state_next = BR_IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state <= BR_IDLE;
    end else begin
        state <= state_next;
    end
end

// Request latch, held until back in IDLE
always_ff @(posedge clk) begin
    if (state == BR_IDLE && bus.req) begin
        cmd_q   <= bus.cmd;
        width_q <= bus.width;
        addr_q  <= bus.addr;
        wdata_q <= bus.wdata;
    end
end

// ------------------------------------------------------------------
// AHB outputs
// ------------------------------------------------------------------
always_comb begin
    case (width_q)
        MEM_WIDTH_BYTE: hsize = HSIZE_BYTE;
        MEM_WIDTH_HALF: hsize = HSIZE_HALF;
        default:        hsize = HSIZE_WORD;
    endcase
end

assign htrans    = (state == BR_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
assign haddr     = addr_q.flat;
assign hwrite    = (cmd_q == MEM_CMD_WR);
assign hwdata    = wdata_q;        // Lane aligned already
assign hprot     = HPROT_DATA;
assign hburst    = HBURST_SINGLE;
assign hmastlock = 1'b0;

// Core side
assign bus.req_ack = (state == BR_IDLE);
assign bus.rdata   = hrdata;

always_comb begin
    if (state == BR_DATA && hready) begin
        bus.resp = (hresp == HRESP_ERROR) ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
    end else begin
        bus.resp = MEM_RESP_NOTRDY;
    end
end

endmodule : dmem_ahb

// File: dmem_timer.sv
// Memory-mapped machine timer
// Prescaled 64-bit mtime, compare register and interrupt output
`timescale 1ns/1ns

module dmem_timer import mem_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    dmem_if.target bus,
    output logic   timer_irq
);

logic               enable;
logic [9:0]         div;
logic [9:0]         presc;
logic [63:0]        mtime;
logic [63:0]        mtimecmp;
logic [2:0]         offs;
logic               accept;
logic               bad;      // Unknown offset or narrow write
logic               wr_ok;
logic [DMEM_DW-1:0] rdata_d;
logic [DMEM_DW-1:0] rdata_q;
mem_resp_e          resp_q;
logic               irq_q;

assign bus.req_ack = 1'b1;
assign accept      = bus.req;
assign offs        = bus.addr.f.word[2:0];

// ------------------------------------------------------------------
// Register decode
// ------------------------------------------------------------------
always_comb begin
    bad     = 1'b0;
    rdata_d = '0;
    case (offs)
        TMR_CTRL:     rdata_d = {31'd0, enable};
        TMR_DIV:      rdata_d = {22'd0, div};
        TMR_MTIME_LO: rdata_d = mtime[31:0];
        TMR_MTIME_HI: rdata_d = mtime[63:32];
        TMR_CMP_LO:   rdata_d = mtimecmp[31:0];
        TMR_CMP_HI:   rdata_d = mtimecmp[63:32];
        default:      bad = 1'b1;
    endcase
    if (bus.cmd == MEM_CMD_WR && bus.width != MEM_WIDTH_WORD)
        bad = 1'b1;
end

assign wr_ok = accept && (bus.cmd == MEM_CMD_WR) && !bad;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        enable   <= 1'b0;
        div      <= '0;
        presc    <= '0;
        mtime    <= '0;
        mtimecmp <= '0;
    end else begin
        if (enable) begin
            if (presc == div) begin
                presc <= '0;
                mtime <= mtime + 64'd1;
            end else begin
                presc <= presc + 10'd1;
            end
        end
        // Software writes win over the tick
        if (wr_ok) begin
            case (offs)
                TMR_CTRL: enable <= bus.wdata[0];
                TMR_DIV: begin
                    div   <= bus.wdata[9:0];
                    presc <= '0;          // Restart the prescale period
                end
                TMR_MTIME_LO: mtime[31:0]     <= bus.wdata;
                TMR_MTIME_HI: mtime[63:32]    <= bus.wdata;
                TMR_CMP_LO:   mtimecmp[31:0]  <= bus.wdata;
                TMR_CMP_HI:   mtimecmp[63:32] <= bus.wdata;
                default: ;
            endcase
        end
    end
end

// Response and interrupt
always_ff @(posedge clk) begin
    if (!rst_n) begin
        resp_q <= MEM_RESP_NOTRDY;
        irq_q  <= 1'b0;
    end else begin
        resp_q <= !accept ? MEM_RESP_NOTRDY : (bad ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK);
        irq_q  <= enable && (mtime >= mtimecmp);
    end
end

always_ff @(posedge clk) begin
    if (accept)
        rdata_q <= rdata_d;
end

assign bus.rdata = rdata_q;
assign bus.resp  = resp_q;
assign timer_irq = irq_q;

endmodule : dmem_timer

// File: dmem_tcm.sv
// Tightly coupled data memory
// Single-cycle word array with byte enables
`timescale 1ns/1ns

module dmem_tcm import mem_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    dmem_if.target bus
);

logic [DMEM_DW-1:0] mem [TCM_WORDS];
logic [7:0]         idx;
logic [3:0]         be;
logic               accept;
logic [DMEM_DW-1:0] rdata_q;
mem_resp_e          resp_q;

assign bus.req_ack = 1'b1;      // Never stalls
assign accept      = bus.req;
assign idx         = bus.addr.f.word;

// Byte lanes from width and byte_sel
always_comb begin
    case (bus.width)
        MEM_WIDTH_BYTE: be = 4'b0001 << bus.addr.f.byte_sel;
        MEM_WIDTH_HALF: be = bus.addr.f.byte_sel[1] ? 4'b1100 : 4'b0011;
        default:        be = 4'b1111;
    endcase
end

always_ff @(posedge clk) begin
    if (accept && bus.cmd == MEM_CMD_WR) begin
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
    end
    if (accept && bus.cmd == MEM_CMD_RD)
        rdata_q <= mem[idx];
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        resp_q <= MEM_RESP_NOTRDY;
    end else begin
        resp_q <= accept ? MEM_RESP_RDY_OK : MEM_RESP_NOTRDY;
    end
end

assign bus.rdata = rdata_q;
assign bus.resp  = resp_q;

endmodule : dmem_tcm

// File: dmem_router.sv
// Data-memory router
// Decodes the request page and steers the response back from one of three targets
`timescale 1ns/1ns

module dmem_router import mem_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    // Core side
    input  logic               dmem_req,
    input  mem_cmd_e           dmem_cmd,
    input  mem_width_e         dmem_width,
    input  logic [DMEM_AW-1:0] dmem_addr,
    input  logic [DMEM_DW-1:0] dmem_wdata,
    output logic               dmem_req_ack,
    output logic [DMEM_DW-1:0] dmem_rdata,
    output mem_resp_e          dmem_resp,
    // Targets
    dmem_if.master             tcm_port,
    dmem_if.master             timer_port,
    dmem_if.master             ahb_port
);

dmem_addr_u core_addr;
logic [1:0] sel_port;     // Decoded target of the current request
logic [1:0] fl_port;      // Target of the request in flight
logic       sel_ack;
logic       resp_done;
logic       can_accept;

assign core_addr = dmem_addr;

// ------------------------------------------------------------------
// Address decode
// ------------------------------------------------------------------
always_comb begin
    if (core_addr.f.page == TCM_PAGE) begin
        sel_port = ROUTE_TCM;
    end else if (core_addr.f.page == TIMER_PAGE) begin
        sel_port = ROUTE_TIMER;
    end else begin
        sel_port = ROUTE_AHB;   // Everything else goes external
    end
end

always_comb begin
    case (sel_port)
        ROUTE_TCM:   sel_ack = tcm_port.req_ack;
        ROUTE_TIMER: sel_ack = timer_port.req_ack;
        default:     sel_ack = ahb_port.req_ack;
    endcase
end

// Response from the port in flight only
always_comb begin
    case (fl_port)
        ROUTE_TCM: begin
            dmem_resp  = tcm_port.resp;
            dmem_rdata = tcm_port.rdata;
        end
        ROUTE_TIMER: begin
            dmem_resp  = timer_port.resp;
            dmem_rdata = timer_port.rdata;
        end
        ROUTE_AHB: begin
            dmem_resp  = ahb_port.resp;
            dmem_rdata = ahb_port.rdata;
        end
        default: begin
            dmem_resp  = MEM_RESP_NOTRDY;
            dmem_rdata = '0;
        end
    endcase
end

assign resp_done    = (dmem_resp != MEM_RESP_NOTRDY);
assign can_accept   = (fl_port == ROUTE_NONE) || resp_done;  // Next may go in the response cycle
assign dmem_req_ack = can_accept & sel_ack;

// ------------------------------------------------------------------
// Request fan-out
// ------------------------------------------------------------------
assign tcm_port.req   = dmem_req & can_accept & (sel_port == ROUTE_TCM);
assign timer_port.req = dmem_req & can_accept & (sel_port == ROUTE_TIMER);
assign ahb_port.req   = dmem_req & can_accept & (sel_port == ROUTE_AHB);

assign tcm_port.cmd     = dmem_cmd;
assign tcm_port.width   = dmem_width;
assign tcm_port.addr    = core_addr;
assign tcm_port.wdata   = dmem_wdata;
assign timer_port.cmd   = dmem_cmd;
assign timer_port.width = dmem_width;
assign timer_port.addr  = core_addr;
assign timer_port.wdata = dmem_wdata;
assign ahb_port.cmd     = dmem_cmd;
assign ahb_port.width   = dmem_width;
assign ahb_port.addr    = core_addr;
assign ahb_port.wdata   = dmem_wdata;

// In-flight tracking
always_ff @(posedge clk) begin
    if (!rst_n) begin
        fl_port <= ROUTE_NONE;
    end else if (dmem_req & dmem_req_ack) begin
        fl_port <= sel_port;
    end else if (resp_done) begin
        fl_port <= ROUTE_NONE;
    end
end

endmodule : dmem_router

// File: dmem_if.sv
// Data-memory request interface
// Master and target modports
`timescale 1ns/1ns

interface dmem_if import mem_pkg::*; ();

logic               req;
mem_cmd_e           cmd;
mem_width_e         width;
dmem_addr_u         addr;
logic [DMEM_DW-1:0] wdata;   // Lane aligned
logic               req_ack;
logic [DMEM_DW-1:0] rdata;   // Valid with a ready response
mem_resp_e          resp;

modport master (
    output req, cmd, width, addr, wdata,
    input  req_ack, rdata, resp
);

modport target (
    input  req, cmd, width, addr, wdata,
    output req_ack, rdata, resp
);

endinterface : dmem_if

// File: ahb_pkg.sv
// AHB-Lite encodings for htrans, hsize, hburst, hprot and hresp
// Phase encoding of the data-memory AHB bridge FSM
package ahb_pkg;

localparam logic [1:0] HTRANS_IDLE   = 2'b00;
localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

localparam logic [2:0] HSIZE_BYTE = 3'b000;
localparam logic [2:0] HSIZE_HALF = 3'b001;
localparam logic [2:0] HSIZE_WORD = 3'b010;

localparam logic [2:0] HBURST_SINGLE = 3'b000;

// Data access, user mode, not bufferable, not cacheable
localparam logic [3:0] HPROT_DATA = 4'b0001;

localparam logic HRESP_OKAY  = 1'b0;
localparam logic HRESP_ERROR = 1'b1;

// Bridge phases
localparam logic [1:0] BR_IDLE = 2'd0;
localparam logic [1:0] BR_ADDR = 2'd1;
localparam logic [1:0] BR_DATA = 2'd2;

endpackage : ahb_pkg

// File: mem_pkg.sv
// Data-memory request types, data widths and address map
// Timer register offsets and the request address union
package mem_pkg;

localparam int DMEM_AW = 32;
localparam int DMEM_DW = 32;

typedef enum logic {
    MEM_CMD_RD = 1'b0,
    MEM_CMD_WR = 1'b1
} mem_cmd_e;

typedef enum logic [1:0] {
    MEM_WIDTH_BYTE = 2'b00,
    MEM_WIDTH_HALF = 2'b01,
    MEM_WIDTH_WORD = 2'b10
} mem_width_e;

typedef enum logic [1:0] {
    MEM_RESP_NOTRDY = 2'b00,
    MEM_RESP_RDY_OK = 2'b01,
    MEM_RESP_RDY_ER = 2'b10
} mem_resp_e;

// Field view of a request address
typedef struct packed {
    logic [21:0] page;
    logic [7:0]  word;
    logic [1:0]  byte_sel;
} dmem_addr_f_t;

typedef union packed {
    logic [DMEM_AW-1:0] flat;  // Bus address
    dmem_addr_f_t       f;     // Page/word/byte fields
} dmem_addr_u;

// ------------------------------------------------------------------
// Address map
// ------------------------------------------------------------------
localparam logic [21:0] TCM_PAGE   = 22'h1200;
localparam int          TCM_WORDS  = 256;
localparam logic [21:0] TIMER_PAGE = 22'h1240;

// Router port ids, NONE means nothing in flight
localparam logic [1:0] ROUTE_AHB   = 2'd0;
localparam logic [1:0] ROUTE_TCM   = 2'd1;
localparam logic [1:0] ROUTE_TIMER = 2'd2;
localparam logic [1:0] ROUTE_NONE  = 2'd3;

// Timer register word offsets
localparam logic [2:0] TMR_CTRL     = 3'd0;  // Bit 0 enable
localparam logic [2:0] TMR_DIV      = 3'd1;  // 10-bit prescaler
localparam logic [2:0] TMR_MTIME_LO = 3'd2;
localparam logic [2:0] TMR_MTIME_HI = 3'd3;
localparam logic [2:0] TMR_CMP_LO   = 3'd4;
localparam logic [2:0] TMR_CMP_HI   = 3'd5;

endpackage : mem_pkg
